// File: design/whack_a_mole_params.svh
`ifndef WHACK_A_MOLE_PARAMS_SVH
`define WHACK_A_MOLE_PARAMS_SVH

////////////////////////////////////////////////////////////
// Round timing, in clock cycles
////////////////////////////////////////////////////////////

// Round start to mole up
`define WAM_SPAWN_DELAY 20

// Hammer window at level 0
`define WAM_HAMMER_WINDOW 400

// Window shrink per difficulty level
`define WAM_WINDOW_STEP 30

////////////////////////////////////////////////////////////
// Difficulty thresholds
////////////////////////////////////////////////////////////

// Score distance between thresholds
`define WAM_LEVEL_STRIDE 10

// Number of thresholds, so highest level
`define WAM_MAX_LEVEL 9

////////////////////////////////////////////////////////////
// Game rules
////////////////////////////////////////////////////////////

`define WAM_START_LIVES 3
`define WAM_SCORE_MAX 127

// Nonzero LFSR start value
`define WAM_LFSR_SEED 8'h5A

`endif

// File: design/whack_a_mole_pkg.sv
`default_nettype none

package whack_a_mole_pkg;

    ////////////////////////////////////////////////////////////
    // Vector types
    ////////////////////////////////////////////////////////////

    // One bit per hole, buttons and moles alike
    typedef logic [3:0] mole_vec_t;

    // Hole index
    typedef logic [1:0] mole_idx_t;

    // Player score, saturating
    typedef logic [6:0] score_t;

    // Remaining lives, 0 only while idle
    typedef logic [1:0] lives_t;

    // Spawn delay and hammer window countdowns
    typedef logic [15:0] tick_t;

    // Mole-pick LFSR state
    typedef logic [7:0] lfsr_t;

    ////////////////////////////////////////////////////////////
    // State and verdict encodings
    ////////////////////////////////////////////////////////////

    // Top-level game phase, exposed on the state pins
    typedef enum logic [1:0] {
        IDLE      = 2'd0,
        WAIT_MOLE = 2'd1,
        MOLE_UP   = 2'd2
    } game_state_t;

    // Outcome of one mole-up
    typedef enum logic [1:0] {
        HIT     = 2'd0,
        WRONG   = 2'd1,
        TIMEOUT = 2'd2
    } verdict_t;

    // Single-cycle verdict from the judge
    typedef struct packed {
        logic     valid;
        verdict_t verdict;
    } round_result_t;

endpackage

`default_nettype wire

// File: design/mole_spawner.sv
`default_nettype none

`include "whack_a_mole_params.svh"

module mole_spawner import whack_a_mole_pkg::*; (
    input  wire           clk,
    input  wire           reset,
    input  wire           round_start,
    input  wire           game_active,
    input  wire round_result_t result,
    output mole_vec_t     moles
);

    ////////////////////////////////////////////////////////////
    // Mole pick LFSR
    ////////////////////////////////////////////////////////////

    lfsr_t     lfsr;
    lfsr_t     lfsr_next;
    // Spawn countdown, nonzero while a mole is pending
    tick_t     spawn_cnt;
    mole_idx_t pick;

    // Fibonacci form, taps 8 6 5 4
    assign lfsr_next = {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};

    // Hole comes from the low bits of the current state
    assign pick = lfsr[1:0];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            lfsr <= `WAM_LFSR_SEED;
        end else if (game_active && round_start) begin
            // One step per round
            lfsr <= lfsr_next;
        end
    end

    ////////////////////////////////////////////////////////////
    // Spawn delay and mole register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            spawn_cnt <= '0;
            moles     <= '0;
        end else if (!game_active) begin
            // Game over or idle, everything dark
            spawn_cnt <= '0;
            moles     <= '0;
        end else begin
            if (round_start) begin
                // Counts down to 1, mole shows on the following cycle
                spawn_cnt <= tick_t'(`WAM_SPAWN_DELAY - 1);
            end else if (spawn_cnt != '0) begin
                spawn_cnt <= spawn_cnt - 1'b1;
                if (spawn_cnt == tick_t'(1)) begin
                    moles <= mole_vec_t'(1) << pick;
                end
            end

            // Verdict is in, hide the mole next cycle
            if (result.valid) begin
                moles <= '0;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////

    // Never more than one hole lit
    a_moles_onehot0: assert property (
        @(posedge clk) disable iff (reset)
        $onehot0(moles)
    );

    // All-zero state would lock the sequence
    a_lfsr_nonzero: assert property (
        @(posedge clk) disable iff (reset)
        lfsr != '0
    );

endmodule

`default_nettype wire

// File: design/hammer_judge.sv
`default_nettype none

`include "whack_a_mole_params.svh"

module hammer_judge import whack_a_mole_pkg::*; (
    input  wire            clk,
    input  wire            reset,
    input  wire mole_vec_t buttons,
    input  wire mole_vec_t moles,
    input  wire score_t    score,
    input  wire            game_active,
    output mole_vec_t      press,
    output round_result_t  result
);

    ////////////////////////////////////////////////////////////
    // Button edges
    ////////////////////////////////////////////////////////////

    mole_vec_t  btn_q;
    mole_vec_t  btn_prev;
    logic       was_up;
    logic       done;
    tick_t      window_cnt;
    logic [3:0] level;
    tick_t      window_len;
    logic       mole_up;
    logic       first_cycle;
    logic       judging;
    logic       hit_now;
    logic       wrong_now;
    logic       timeout_now;

    // Buttons arrive debounced, one register stage is enough
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            btn_q    <= '0;
            btn_prev <= '0;
        end else begin
            btn_q    <= buttons;
            btn_prev <= btn_q;
        end
    end

    // One-cycle pulse per rising edge
    assign press = btn_q & ~btn_prev;

    ////////////////////////////////////////////////////////////
    // Difficulty
    ////////////////////////////////////////////////////////////

    // Thresholds strictly exceeded, loop bound caps the level
    always_comb begin
        level = '0;
        for (int k = 1; k <= `WAM_MAX_LEVEL; k++) begin
            if (int'(score) > k * `WAM_LEVEL_STRIDE) begin
                level = level + 4'd1;
            end
        end
    end

    assign window_len = tick_t'(`WAM_HAMMER_WINDOW)
                      - tick_t'(`WAM_WINDOW_STEP) * tick_t'(level);

    ////////////////////////////////////////////////////////////
    // Hammer window
    ////////////////////////////////////////////////////////////

    assign mole_up     = (moles != '0);
    assign first_cycle = mole_up && !was_up;
    assign judging     = mole_up && game_active && !done;

    // Right hole vs any other hole
    assign hit_now     = judging && ((press & moles) != '0);
    assign wrong_now   = judging && ((press & ~moles) != '0);
    // Counter is only valid after the load in the first cycle
    assign timeout_now = judging && !first_cycle && (window_cnt == '0);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            was_up     <= 1'b0;
            done       <= 1'b0;
            window_cnt <= '0;
        end else begin
            was_up <= mole_up;

            // One verdict per mole-up, rearm once dark
            if (!game_active || !mole_up) begin
                done <= 1'b0;
            end else if (hit_now || wrong_now || timeout_now) begin
                done <= 1'b1;
            end

            if (first_cycle) begin
                window_cnt <= window_len - 1'b1;
            end else if (judging && window_cnt != '0) begin
                window_cnt <= window_cnt - 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Verdict register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            result <= '{valid: 1'b0, verdict: HIT};
        end else begin
            result.valid <= hit_now || wrong_now || timeout_now;
            // Hit beats a simultaneous wrong press
            if (hit_now) begin
                result.verdict <= HIT;
            end else if (wrong_now) begin
                result.verdict <= WRONG;
            end else begin
                result.verdict <= TIMEOUT;
            end
        end
    end

    // The mole must go dark before another verdict
    a_single_verdict: assert property (
        @(posedge clk) disable iff (reset)
        result.valid |=> !result.valid
    );

endmodule

`default_nettype wire

// File: design/game_control.sv
`default_nettype none

`include "whack_a_mole_params.svh"

module game_control import whack_a_mole_pkg::*; (
    input  wire                clk,
    input  wire                reset,
    input  wire mole_vec_t     press,
    input  wire mole_vec_t     moles,
    input  wire round_result_t result,
    output logic               round_start,
    output logic               game_active,
    output score_t             score,
    output lives_t             lives,
    output game_state_t        state
);

    ////////////////////////////////////////////////////////////
    // Derived levels
    ////////////////////////////////////////////////////////////

    logic   last_life;
    score_t score_inc;

    // Judge and spawner run only during a game
    assign game_active = (state != IDLE);

    // Miss on this life ends the game
    assign last_life = (lives <= lives_t'(1));

    // Saturating increment
    assign score_inc = (score == score_t'(`WAM_SCORE_MAX)) ? score : score + 1'b1;

    ////////////////////////////////////////////////////////////
    // Game FSM with score and lives
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state       <= IDLE;
            score       <= '0;
            lives       <= '0;
            round_start <= 1'b0;
        end else begin
            // Pulse by default
            round_start <= 1'b0;

            if (game_active && result.valid) begin
                // Round over, book the verdict
                if (result.verdict == HIT) begin
                    score       <= score_inc;
                    round_start <= 1'b1;
                    state       <= WAIT_MOLE;
                end else if (!last_life) begin
                    lives       <= lives - 1'b1;
                    round_start <= 1'b1;
                    state       <= WAIT_MOLE;
                end else begin
                    // Out of lives, moles go dark with game_active
                    lives <= '0;
                    state <= IDLE;
                end
            end else begin
                case (state)
                    IDLE: begin
                        // Any button starts a fresh game
                        if (press != '0) begin
                            score       <= '0;
                            lives       <= lives_t'(`WAM_START_LIVES);
                            round_start <= 1'b1;
                            state       <= WAIT_MOLE;
                        end
                    end
                    WAIT_MOLE: begin
                        if (moles != '0) begin
                            state <= MOLE_UP;
                        end
                    end
                    MOLE_UP: begin
                        // Held until the judge reports
                        state <= MOLE_UP;
                    end
                    default: begin
                        state <= IDLE;
                    end
                endcase
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////

    // A running game always has a life left
    a_lives_in_game: assert property (
        @(posedge clk) disable iff (reset)
        (state != IDLE) |-> (lives != '0)
    );

endmodule

`default_nettype wire

// File: design/whack_a_mole.sv
`default_nettype none

module whack_a_mole import whack_a_mole_pkg::*; (
    input  wire            clk,
    input  wire            reset,
    input  wire mole_vec_t buttons,
    output mole_vec_t      moles,
    output score_t         score,
    output lives_t         lives,
    output game_state_t    state
);

    ////////////////////////////////////////////////////////////
    // Internal nets
    ////////////////////////////////////////////////////////////

    // Rising edges, used by the FSM only while idle
    mole_vec_t     press;
    // One pulse per round
    logic          round_start;
    logic          game_active;
    // Judge verdict pulse
    round_result_t result;

    ////////////////////////////////////////////////////////////
    // Peers
    ////////////////////////////////////////////////////////////

    mole_spawner u_mole_spawner (
        .clk         (clk),
        .reset       (reset),
        .round_start (round_start),
        .game_active (game_active),
        .result      (result),
        .moles       (moles)
    );

    hammer_judge u_hammer_judge (
        .clk         (clk),
        .reset       (reset),
        .buttons     (buttons),
        .moles       (moles),
        .score       (score),
        .game_active (game_active),
        .press       (press),
        .result      (result)
    );

    game_control u_game_control (
        .clk         (clk),
        .reset       (reset),
        .press       (press),
        .moles       (moles),
        .result      (result),
        .round_start (round_start),
        .game_active (game_active),
        .score       (score),
        .lives       (lives),
        .state       (state)
    );

endmodule

`default_nettype wire

// File: testbench/tb_whack_a_mole.sv
`default_nettype none

`include "whack_a_mole_params.svh"

module tb_whack_a_mole import whack_a_mole_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int MAX_TESTS = 64;

    logic        clk;
    logic        reset;
    mole_vec_t   buttons;
    mole_vec_t   moles;
    score_t      score;
    lives_t      lives;
    game_state_t state;

    // Test table with one entry per data line
    int    actions [MAX_TESTS];
    int    exp_scores [MAX_TESTS];
    int    exp_lives [MAX_TESTS];
    int    num_tests;
    logic  loaded;
    int    errors;
    int    test_errors;
    int    failed_tests;
    int    seed;
    // Model of the mole pick sequence
    lfsr_t lfsr_model;
    // Score seen by the judge at mole up
    int    cur_score;

    always #50 clk = ~clk;

    whack_a_mole u_dut (
        .clk     (clk),
        .reset   (reset),
        .buttons (buttons),
        .moles   (moles),
        .score   (score),
        .lives   (lives),
        .state   (state)
    );

    ////////////////////////////////////////////////////////////
    // Game rule models
    ////////////////////////////////////////////////////////////

    // Base window minus one step per threshold strictly exceeded
    function automatic int window_for(input int s);
        int level;
        level = 0;
        for (int k = 1; k <= `WAM_MAX_LEVEL; k++) begin
            if (s > k * `WAM_LEVEL_STRIDE) begin
                level++;
            end
        end
        return `WAM_HAMMER_WINDOW - `WAM_WINDOW_STEP * level;
    endfunction

    // Taps 8 6 5 4 with feedback into bit 0
    function automatic lfsr_t lfsr_step(input lfsr_t s);
        return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
    endfunction

    task automatic check_value(input string name, input int expected, input int actual);
        if (expected != actual) begin
            $display("Error at %0t ns: %s expected %0d, got %0d", $time, name, expected, actual);
            errors++;
            test_errors++;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Player actions entered on a falling edge
    ////////////////////////////////////////////////////////////

    // One-cycle button press on a single hole
    task automatic tap_button(input mole_idx_t idx);
        buttons = mole_vec_t'(1) << idx;
        @(negedge clk);
        buttons = '0;
    endtask

    task automatic wait_mole_dark(output int lit);
        lit = 0;
        while (moles != '0) begin
            lit++;
            @(negedge clk);
        end
        @(negedge clk);
    endtask

    task automatic run_test(input int i);
        int          window;
        int          delay;
        int          lit;
        mole_idx_t   target;
        mole_idx_t   other;
        mole_vec_t   exp_moles;
        game_state_t exp_state;
        test_errors = 0;
        window = window_for(cur_score);
        case (actions[i])
            0: begin
                // Any hole starts a game from idle
                tap_button(mole_idx_t'(i));
                while (state == IDLE) begin
                    @(negedge clk);
                end
            end
            4: begin
                // Press between rounds changes nothing
                tap_button(mole_idx_t'(i));
                @(negedge clk);
            end
            default: begin
                lfsr_model = lfsr_step(lfsr_model);
                target = lfsr_model[1:0];
                other = target + 2'd1;
                exp_moles = mole_vec_t'(1) << target;
                while (moles == '0) begin
                    @(negedge clk);
                end
                check_value("moles", int'(exp_moles), int'(moles));
                if (actions[i] == 3) begin
                    wait_mole_dark(lit);
                    // Window plus verdict and clear cycles
                    check_value("mole lit cycles", window + 2, lit);
                end else begin
                    if (actions[i] == 5) begin
                        delay = window - 2;
                    end else begin
                        delay = {$random(seed)} % (window - 4);
                    end
                    repeat (delay) @(negedge clk);
                    tap_button((actions[i] == 2) ? other : target);
                    wait_mole_dark(lit);
                end
            end
        endcase
        exp_state = (exp_lives[i] == 0) ? IDLE : WAIT_MOLE;
        check_value("score", exp_scores[i], int'(score));
        check_value("lives", exp_lives[i], int'(lives));
        check_value("state", int'(exp_state), int'(state));
        // Dark between rounds and after game over
        check_value("moles", 0, int'(moles));
        cur_score = exp_scores[i];
        if (test_errors != 0) begin
            failed_tests++;
        end
        $display("Test %0d action %0d score %0d lives %0d: %s", i, actions[i],
                 score, lives, (test_errors == 0) ? "ok" : "FAILED");
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////

    initial begin
        int    fd;
        int    act;
        int    sc;
        int    lv;
        string line;
        clk = 1'b0;
        reset = 1'b1;
        buttons = '0;
        errors = 0;
        failed_tests = 0;
        num_tests = 0;
        loaded = 1'b0;
        seed = 76907;
        lfsr_model = `WAM_LFSR_SEED;
        cur_score = 0;
        fd = $fopen("testbench/whack_a_mole_tests.txt", "r");
        if (fd == 0) begin
            $display("Could not open the test data file");
            $display("Checks failed");
            $finish;
        end else begin
            while (!$feof(fd) && num_tests < MAX_TESTS) begin
                // Comment and blank lines do not scan as three numbers
                if ($fgets(line, fd) != 0 &&
                    $sscanf(line, "%d %d %d", act, sc, lv) == 3) begin
                    actions[num_tests] = act;
                    exp_scores[num_tests] = sc;
                    exp_lives[num_tests] = lv;
                    num_tests++;
                end
            end
            $fclose(fd);
            loaded = 1'b1;
            repeat (5) @(posedge clk);
            @(negedge clk);
            reset = 1'b0;
            // Idle and dark out of reset
            test_errors = 0;
            check_value("state", int'(IDLE), int'(state));
            check_value("score", 0, int'(score));
            check_value("lives", 0, int'(lives));
            check_value("moles", 0, int'(moles));
            $display("Reset check: %s", (test_errors == 0) ? "ok" : "FAILED");
            for (int i = 0; i < num_tests; i++) begin
                run_test(i);
            end
            $display("Tests run %0d, tests failing %0d, errors %0d",
                     num_tests, failed_tests, errors);
            if (errors == 0) begin
                $display("All checks passed");
            end else begin
                $display("Checks failed");
            end
            $finish;
        end
    end

    // Worst case per test is a full spawn plus window
    initial begin
        wait (loaded);
        #((num_tests + 1) * (`WAM_SPAWN_DELAY + `WAM_HAMMER_WINDOW + 50) * 100);
        $display("Watchdog expired, the DUT stopped responding");
        $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: testbench/whack_a_mole_tests.txt
// Columns: action, expected score, expected lives after the action
// Actions: 0 start, 1 hit, 2 wrong hole, 3 timeout, 4 stray press, 5 late hit
0 0 3
1 1 3
4 1 3
2 1 2
1 2 2
1 3 2
1 4 2
1 5 2
1 6 2
1 7 2
1 8 2
1 9 2
5 10 2
1 11 2
5 12 2
1 13 2
1 14 2
1 15 2
1 16 2
1 17 2
1 18 2
1 19 2
1 20 2
5 21 2
5 22 2
3 22 1
2 22 0

// File: whack_a_mole.f
+incdir+design
design/whack_a_mole_pkg.sv
design/mole_spawner.sv
design/hammer_judge.sv
design/game_control.sv
design/whack_a_mole.sv
testbench/tb_whack_a_mole.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert
TOP       := tb_whack_a_mole
FILELIST  := whack_a_mole.f
OBJ_DIR   := obj_dir
PASS_MSG  := All checks passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
